// File: Makefile
TOP := soc_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o soc_ctrl_sim
	./obj_dir/soc_ctrl_sim

clean:
	rm -rf obj_dir

// File: design/apb_reg_decode.sv
// apb front end decoding the word index into block selects, write strobe and read mux
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module apb_reg_decode import soc_ctrl_pkg::*; (
   input  logic                       HCLK,
   input  logic                       HRESETn,
   input  logic [`SOC_APB_ADDR_W-1:0] paddr_i,
   input  logic [`SOC_DATA_W-1:0]     pwdata_i,
   input  logic                       pwrite_i,
   input  logic                       psel_i,
   input  logic                       penable_i,
   output logic [`SOC_DATA_W-1:0]     prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o,
   input  soc_word_u                  pad_rdata_i,
   input  soc_word_u                  boot_rdata_i,
   input  soc_word_u                  stat_rdata_i,
   output logic                       wr_en_o,
   output soc_word_u                  wdata_o,
   output reg_idx_t                   local_idx_o,
   output logic                       pad_sel_o,
   output logic                       boot_sel_o,
   output logic                       stat_sel_o
);

   reg_idx_t word_idx;

   assign word_idx = paddr_i[8:2];          // upper address bits alias
   assign wr_en_o  = psel_i & penable_i & pwrite_i;
   assign wdata_o.raw = pwdata_i;

   // zero wait states and no error response
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   // each range is matched on its own, an overlap in the map raises two selects
   always_comb
   begin
      pad_sel_o   = 1'b0;
      boot_sel_o  = 1'b0;
      stat_sel_o  = 1'b0;
      local_idx_o = '0;
      if (psel_i)
      begin
         if ((word_idx >= `REG_PADFUN0) && (word_idx < `REG_PADFUN0 + `SOC_NUM_PADFUN))
         begin
            pad_sel_o   = 1'b1;
            local_idx_o = reg_idx_t'(word_idx - `REG_PADFUN0);
         end
         if ((word_idx >= `REG_PADCFG0) &&
             (word_idx < `REG_PADCFG0 + `SOC_NUM_PADCFG))
         begin
            pad_sel_o   = 1'b1;
            local_idx_o = reg_idx_t'(`PAD_LOC_CFG0 + (word_idx - `REG_PADCFG0));
         end
         case (word_idx)
            `REG_FCBOOT, `REG_FCFETCH, `REG_CORESTATUS, `REG_CS_RO:
            begin
               boot_sel_o  = 1'b1;
               local_idx_o = reg_idx_t'(word_idx - `REG_FCBOOT);
            end
            `REG_INFO, `REG_JTAGREG, `REG_BOOTSEL:
            begin
               stat_sel_o  = 1'b1;
               local_idx_o = reg_idx_t'(word_idx - `REG_INFO);
            end
            default: ;                      // not a boot or status word
         endcase
      end
   end

   // read data from the selected block or zero when unmapped
   always_comb
   begin
      if (pad_sel_o)
         prdata_o = pad_rdata_i.raw;
      else if (boot_sel_o)
         prdata_o = boot_rdata_i.raw;
      else if (stat_sel_o)
         prdata_o = stat_rdata_i.raw;
      else
         prdata_o = '0;
   end

   a_sel_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
      $onehot0({pad_sel_o, boot_sel_o, stat_sel_o}))
      else $error("more than one register block selected");

   // an access phase always belongs to a selected transfer
   a_penable_psel: assert property (@(posedge HCLK) disable iff (!HRESETn)
      penable_i |-> psel_i)
      else $error("penable without psel");

endmodule

// File: design/fc_boot_regs.sv
// fabric controller boot registers: boot address, fetch enable and core status
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module fc_boot_regs import soc_ctrl_pkg::*; (
   input  logic                   HCLK,
   input  logic                   HRESETn,
   input  logic                   sel_i,
   input  logic                   wr_en_i,
   input  reg_idx_t               local_idx_i,
   input  soc_word_u              wdata_i,
   input  logic                   fc_fetch_en_valid_i,
   input  logic                   fc_fetch_en_i,
   output soc_word_u              rdata_o,
   output logic [`SOC_DATA_W-1:0] fc_bootaddr_o,
   output logic                   fc_fetchen_o
);

   localparam reg_idx_t LOC_FCBOOT     = reg_idx_t'(`REG_FCBOOT - `REG_FCBOOT);
   localparam reg_idx_t LOC_FCFETCH    = reg_idx_t'(`REG_FCFETCH - `REG_FCBOOT);
   localparam reg_idx_t LOC_CORESTATUS = reg_idx_t'(`REG_CORESTATUS - `REG_FCBOOT);
   localparam reg_idx_t LOC_CS_RO      = reg_idx_t'(`REG_CS_RO - `REG_FCBOOT);

   logic [`SOC_DATA_W-1:0] r_bootaddr;
   logic                   r_fetchen;
   logic [`SOC_DATA_W-1:0] r_corestatus;   // eoc in bit 31

   assign fc_bootaddr_o = r_bootaddr;
   assign fc_fetchen_o  = r_fetchen;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_bootaddr   <= `SOC_BOOTADDR_RST;
         r_fetchen    <= 1'b0;             // fc idle until enabled
         r_corestatus <= '0;
      end
      else
      begin
         if (fc_fetch_en_valid_i)
            r_fetchen <= fc_fetch_en_i;    // external override
         if (sel_i && wr_en_i)
         begin
            case (local_idx_i)
               LOC_FCBOOT:     r_bootaddr   <= wdata_i.raw;
               LOC_FCFETCH:    r_fetchen    <= wdata_i.raw[0];  // apb wins
               LOC_CORESTATUS: r_corestatus <= wdata_i.raw;
               default: ;                  // mirror is read-only
            endcase
         end
      end
   end

   always_comb
   begin
      rdata_o.raw = '0;
      if (sel_i)
      begin
         case (local_idx_i)
            LOC_FCBOOT:                rdata_o.raw = r_bootaddr;
            LOC_FCFETCH:               rdata_o.raw[0] = r_fetchen;
            LOC_CORESTATUS, LOC_CS_RO: rdata_o.raw = r_corestatus;
            default: ;
         endcase
      end
   end

endmodule

// File: design/pad_ctrl_regs.sv
// pad control registers: function select and configuration for all pads
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module pad_ctrl_regs import soc_ctrl_pkg::*; (
   input  logic                            HCLK,
   input  logic                            HRESETn,
   input  logic                            sel_i,
   input  logic                            wr_en_i,
   input  reg_idx_t                        local_idx_i,
   input  soc_word_u                       wdata_i,
   output soc_word_u                       rdata_o,
   output pad_mux_t [`SOC_NUM_PADS-1:0]    pad_mux_o,
   output pad_cfg_t [`SOC_NUM_PADS-1:0]    pad_cfg_o
);

   pad_mux_t [`SOC_NUM_PADS-1:0] r_mux;
   pad_cfg_t [`SOC_NUM_PADS-1:0] r_cfg;

   logic       is_fun;
   logic       is_cfg;
   logic [1:0] fun_reg;                    // which select word
   logic [3:0] cfg_reg;                    // which config word

   assign is_fun  = (local_idx_i < `SOC_NUM_PADFUN);
   assign is_cfg  = (local_idx_i >= `PAD_LOC_CFG0) &&
                    (local_idx_i < `PAD_LOC_CFG0 + `SOC_NUM_PADCFG);
   assign fun_reg = local_idx_i[1:0];
   assign cfg_reg = local_idx_i[3:0];

   assign pad_mux_o = r_mux;
   assign pad_cfg_o = r_cfg;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_mux <= '0;
         r_cfg <= '1;                      // pads start fully enabled
      end
      else if (sel_i && wr_en_i)
      begin
         if (is_fun)
         begin
            for (int i = 0; i < `SOC_PADS_PER_FUN; i++)
               r_mux[{fun_reg, 4'(i)}] <= wdata_i.mux[i];
         end
         else if (is_cfg)
         begin
            // all six bits kept, upper two of each byte dropped
            for (int i = 0; i < `SOC_PADS_PER_CFG; i++)
               r_cfg[{cfg_reg, 2'(i)}] <= wdata_i.cfg[i].cfg;
         end
      end
   end

   always_comb
   begin
      rdata_o.raw = '0;
      if (sel_i && is_fun)
      begin
         for (int i = 0; i < `SOC_PADS_PER_FUN; i++)
            rdata_o.mux[i] = r_mux[{fun_reg, 4'(i)}];
      end
      else if (sel_i && is_cfg)
      begin
         for (int i = 0; i < `SOC_PADS_PER_CFG; i++)
            rdata_o.cfg[i].cfg = r_cfg[{cfg_reg, 2'(i)}];  // rsvd stays zero
      end
   end

   // decoder offsets the config bank, so local 4..15 must never be written
   a_no_gap_write: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (sel_i && wr_en_i) |-> !(local_idx_i inside {[4:15]}))
      else $error("pad write into unused local index range");

endmodule

// File: design/soc_ctrl_defines.svh
// soc control register map: word offsets, field widths, counts and reset values
`ifndef SOC_CTRL_DEFINES_SVH
`define SOC_CTRL_DEFINES_SVH

`define SOC_APB_ADDR_W   12
`define SOC_DATA_W       32
`define SOC_NUM_PADS     64
`define SOC_PADCFG_BITS  6            // pu, pd, st, slew, 2b drive
`define SOC_NB_CORES     4
`define SOC_NB_CLUSTERS  0
`define SOC_JTAG_W       8
`define SOC_BOOTADDR_RST 32'h1A00_0080

// pad register counts and pads packed per word
`define SOC_NUM_PADFUN   4
`define SOC_NUM_PADCFG   16
`define SOC_PADS_PER_FUN 16
`define SOC_PADS_PER_CFG 4

// word indices, byte offset = index * 4
`define REG_INFO         7'h00        // 0x00 cores / clusters
`define REG_FCBOOT       7'h01        // 0x04
`define REG_FCFETCH      7'h02        // 0x08
`define REG_PADFUN0      7'h04        // 0x10 .. 0x1c
`define REG_PADCFG0      7'h08        // 0x20 .. 0x5c
`define REG_JTAGREG      7'h1D        // 0x74
`define REG_CORESTATUS   7'h28        // 0xa0
`define REG_CS_RO        7'h30        // 0xc0 read-only mirror
`define REG_BOOTSEL      7'h31        // 0xc4

// pad config bank sits at local index 16 so bit 4 tells the banks apart
`define PAD_LOC_CFG0     7'd16

`endif

// File: design/soc_ctrl_pkg.sv
// soc control types: pad fields, word index and the decoded bus data word
`include "soc_ctrl_defines.svh"

package soc_ctrl_pkg;

   typedef logic [1:0] pad_mux_t;          // pad function select

   typedef struct packed {
      logic [1:0] drive;                   // drive strength
      logic       slew;                    // slew rate limit
      logic       st;                      // schmitt trigger
      logic       pd;                      // pull down
      logic       pu;                      // pull up, bit 0
   } pad_cfg_t;

   typedef logic [6:0] reg_idx_t;

   typedef struct packed {
      logic [7-`SOC_PADCFG_BITS:0] rsvd;   // reads as zero
      pad_cfg_t                    cfg;
   } pad_cfg_byte_t;

   // same 32 bits seen as a plain word, 16 pad selects or 4 pad configs
   typedef union packed {
      logic [`SOC_DATA_W-1:0] raw;
      pad_mux_t [15:0]        mux;
      pad_cfg_byte_t [3:0]    cfg;
   } soc_word_u;

endpackage

// File: design/soc_ctrl_top.sv
// soc control register block top: apb front end and the three register groups
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module soc_ctrl_top (
   input  logic                                     HCLK,
   input  logic                                     HRESETn,
   input  logic [`SOC_APB_ADDR_W-1:0]               paddr_i,
   input  logic [`SOC_DATA_W-1:0]                   pwdata_i,
   input  logic                                     pwrite_i,
   input  logic                                     psel_i,
   input  logic                                     penable_i,
   output logic [`SOC_DATA_W-1:0]                   prdata_o,
   output logic                                     pready_o,
   output logic                                     pslverr_o,
   input  logic [1:0]                               bootsel_i,
   input  logic                                     fc_fetch_en_valid_i,
   input  logic                                     fc_fetch_en_i,
   input  logic [`SOC_JTAG_W-1:0]                   soc_jtag_reg_i,
   output soc_ctrl_pkg::pad_mux_t [`SOC_NUM_PADS-1:0] pad_mux_o,
   output soc_ctrl_pkg::pad_cfg_t [`SOC_NUM_PADS-1:0] pad_cfg_o,
   output logic [`SOC_JTAG_W-1:0]                   soc_jtag_reg_o,
   output logic [`SOC_DATA_W-1:0]                   fc_bootaddr_o,
   output logic                                     fc_fetchen_o
);

   soc_ctrl_pkg::soc_word_u pad_rdata;
   soc_ctrl_pkg::soc_word_u boot_rdata;
   soc_ctrl_pkg::soc_word_u stat_rdata;
   soc_ctrl_pkg::soc_word_u wdata;
   soc_ctrl_pkg::reg_idx_t  local_idx;
   logic                    wr_en;
   logic                    pad_sel;
   logic                    boot_sel;
   logic                    stat_sel;

   apb_reg_decode u_decode (
      .HCLK         (HCLK),
      .HRESETn      (HRESETn),
      .paddr_i      (paddr_i),
      .pwdata_i     (pwdata_i),
      .pwrite_i     (pwrite_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .pad_rdata_i  (pad_rdata),
      .boot_rdata_i (boot_rdata),
      .stat_rdata_i (stat_rdata),
      .wr_en_o      (wr_en),
      .wdata_o      (wdata),
      .local_idx_o  (local_idx),
      .pad_sel_o    (pad_sel),
      .boot_sel_o   (boot_sel),
      .stat_sel_o   (stat_sel)
   );

   pad_ctrl_regs u_pad (
      .HCLK        (HCLK),
      .HRESETn     (HRESETn),
      .sel_i       (pad_sel),
      .wr_en_i     (wr_en),
      .local_idx_i (local_idx),
      .wdata_i     (wdata),
      .rdata_o     (pad_rdata),
      .pad_mux_o   (pad_mux_o),
      .pad_cfg_o   (pad_cfg_o)
   );

   fc_boot_regs u_boot (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .sel_i               (boot_sel),
      .wr_en_i             (wr_en),
      .local_idx_i         (local_idx),
      .wdata_i             (wdata),
      .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
      .fc_fetch_en_i       (fc_fetch_en_i),
      .rdata_o             (boot_rdata),
      .fc_bootaddr_o       (fc_bootaddr_o),
      .fc_fetchen_o        (fc_fetchen_o)
   );

   soc_status_regs u_stat (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .sel_i          (stat_sel),
      .wr_en_i        (wr_en),
      .local_idx_i    (local_idx),
      .wdata_i        (wdata),
      .soc_jtag_reg_i (soc_jtag_reg_i),
      .bootsel_i      (bootsel_i),
      .rdata_o        (stat_rdata),
      .soc_jtag_reg_o (soc_jtag_reg_o)
   );

endmodule

// File: design/soc_status_regs.sv
// soc status registers: info word, jtag exchange and sampled boot select pins
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module soc_status_regs import soc_ctrl_pkg::*; (
   input  logic                   HCLK,
   input  logic                   HRESETn,
   input  logic                   sel_i,
   input  logic                   wr_en_i,
   input  reg_idx_t               local_idx_i,
   input  soc_word_u              wdata_i,
   input  logic [`SOC_JTAG_W-1:0] soc_jtag_reg_i,
   input  logic [1:0]             bootsel_i,
   output soc_word_u              rdata_o,
   output logic [`SOC_JTAG_W-1:0] soc_jtag_reg_o
);

   localparam reg_idx_t LOC_INFO    = reg_idx_t'(`REG_INFO - `REG_INFO);
   localparam reg_idx_t LOC_JTAGREG = reg_idx_t'(`REG_JTAGREG - `REG_INFO);
   localparam reg_idx_t LOC_BOOTSEL = reg_idx_t'(`REG_BOOTSEL - `REG_INFO);

   logic [`SOC_JTAG_W-1:0] r_jtag_out;
   logic [`SOC_JTAG_W-1:0] r_jtag_meta;     // first sync stage
   logic [`SOC_JTAG_W-1:0] r_jtag_sync;
   logic [1:0]             r_bootsel;

   assign soc_jtag_reg_o = r_jtag_out;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_jtag_out  <= '0;
         r_jtag_meta <= '0;
         r_jtag_sync <= '0;
         r_bootsel   <= '0;
      end
      else
      begin
         r_jtag_meta <= soc_jtag_reg_i;     // jtag side is asynchronous
         r_jtag_sync <= r_jtag_meta;
         r_bootsel   <= bootsel_i;
         if (sel_i && wr_en_i && (local_idx_i == LOC_JTAGREG))
            r_jtag_out <= wdata_i.raw[`SOC_JTAG_W-1:0];
      end
   end

   always_comb
   begin
      rdata_o.raw = '0;
      if (sel_i)
      begin
         case (local_idx_i)
            LOC_INFO:    rdata_o.raw = {16'(`SOC_NB_CORES), 16'(`SOC_NB_CLUSTERS)};
            LOC_JTAGREG: rdata_o.raw[2*`SOC_JTAG_W-1:0] = {r_jtag_sync, r_jtag_out};
            LOC_BOOTSEL: rdata_o.raw[1:0] = r_bootsel;
            default: ;
         endcase
      end
   end

endmodule

// File: sim/soc_ctrl_tb_model.svh
// register model of the soc control block: expected contents, write rules and readback
`ifndef SOC_CTRL_TB_MODEL_SVH
`define SOC_CTRL_TB_MODEL_SVH

`include "soc_ctrl_defines.svh"

pad_mux_t [`SOC_NUM_PADS-1:0] m_mux;
pad_cfg_t [`SOC_NUM_PADS-1:0] m_cfg;
logic [`SOC_DATA_W-1:0]       m_bootaddr;
logic                         m_fetchen;
logic [`SOC_DATA_W-1:0]       m_corestatus;
logic [`SOC_JTAG_W-1:0]       m_jtag_out;
logic [`SOC_JTAG_W-1:0]       m_jtag_in;      // settled synchronizer output
logic [1:0]                   m_bootsel;

function automatic void model_reset();
   m_mux        = '0;
   m_cfg        = '1;                         // pads come up all ones
   m_bootaddr   = `SOC_BOOTADDR_RST;
   m_fetchen    = 1'b0;
   m_corestatus = '0;
   m_jtag_out   = '0;
   m_jtag_in    = '0;
   m_bootsel    = '0;
endfunction

function automatic bit in_padfun(reg_idx_t idx);
   return (int'(idx) >= `REG_PADFUN0) && (int'(idx) < `REG_PADFUN0 + `SOC_NUM_PADFUN);
endfunction

function automatic bit in_padcfg(reg_idx_t idx);
   return (int'(idx) >= `REG_PADCFG0) && (int'(idx) < `REG_PADCFG0 + `SOC_NUM_PADCFG);
endfunction

function automatic bit model_mapped(reg_idx_t idx);
   return in_padfun(idx) || in_padcfg(idx) ||
          (idx inside {`REG_INFO, `REG_FCBOOT, `REG_FCFETCH, `REG_JTAGREG,
                       `REG_CORESTATUS, `REG_CS_RO, `REG_BOOTSEL});
endfunction

function automatic void model_write(reg_idx_t idx, logic [`SOC_DATA_W-1:0] data);
   int base;
   if (in_padfun(idx))
   begin
      base = (int'(idx) - `REG_PADFUN0) * `SOC_PADS_PER_FUN;
      for (int i = 0; i < `SOC_PADS_PER_FUN; i++)
         m_mux[base + i] = data[2*i +: 2];     // two bits per pad
   end
   else if (in_padcfg(idx))
   begin
      base = (int'(idx) - `REG_PADCFG0) * `SOC_PADS_PER_CFG;
      for (int i = 0; i < `SOC_PADS_PER_CFG; i++)
         m_cfg[base + i] = data[8*i +: `SOC_PADCFG_BITS];
   end
   else
   begin
      case (idx)
         `REG_FCBOOT:     m_bootaddr   = data;
         `REG_FCFETCH:    m_fetchen    = data[0];
         `REG_CORESTATUS: m_corestatus = data;
         `REG_JTAGREG:    m_jtag_out   = data[`SOC_JTAG_W-1:0];
         default: ;                           // read-only or unmapped
      endcase
   end
endfunction

function automatic soc_word_u model_read(reg_idx_t idx);
   soc_word_u w;
   int        base;
   w.raw = '0;
   if (in_padfun(idx))
   begin
      base = (int'(idx) - `REG_PADFUN0) * `SOC_PADS_PER_FUN;
      for (int i = 0; i < `SOC_PADS_PER_FUN; i++)
         w.raw[2*i +: 2] = m_mux[base + i];
   end
   else if (in_padcfg(idx))
   begin
      base = (int'(idx) - `REG_PADCFG0) * `SOC_PADS_PER_CFG;
      for (int i = 0; i < `SOC_PADS_PER_CFG; i++)
         w.raw[8*i +: `SOC_PADCFG_BITS] = m_cfg[base + i];  // top two bits zero
   end
   else
   begin
      case (idx)
         `REG_INFO:
         begin
            w.raw[31:16] = 16'(`SOC_NB_CORES);
            w.raw[15:0]  = 16'(`SOC_NB_CLUSTERS);
         end
         `REG_FCBOOT:                 w.raw    = m_bootaddr;
         `REG_FCFETCH:                w.raw[0] = m_fetchen;
         `REG_CORESTATUS, `REG_CS_RO: w.raw    = m_corestatus;
         `REG_JTAGREG:
         begin
            w.raw[15:8] = m_jtag_in;
            w.raw[7:0]  = m_jtag_out;
         end
         `REG_BOOTSEL:                w.raw[1:0] = m_bootsel;
         default: ;
      endcase
   end
   return w;
endfunction

`endif

// File: sim/soc_ctrl_tb.sv
// testbench for the soc control block: random apb traffic checked against a register model
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module soc_ctrl_tb import soc_ctrl_pkg::*; ();

   localparam int READY_TIMEOUT = 16;         // cycles

   logic                         HCLK = 1'b0;
   logic                         HRESETn;
   logic [`SOC_APB_ADDR_W-1:0]   paddr;
   logic [`SOC_DATA_W-1:0]       pwdata;
   logic                         pwrite;
   logic                         psel;
   logic                         penable;
   logic [`SOC_DATA_W-1:0]       prdata;
   logic                         pready;
   logic                         pslverr;
   logic [1:0]                   bootsel;
   logic                         fetch_valid;
   logic                         fetch_en;
   logic [`SOC_JTAG_W-1:0]       jtag_in;
   pad_mux_t [`SOC_NUM_PADS-1:0] pad_mux;
   pad_cfg_t [`SOC_NUM_PADS-1:0] pad_cfg;
   logic [`SOC_JTAG_W-1:0]       jtag_out;
   logic [`SOC_DATA_W-1:0]       bootaddr;
   logic                         fetchen;

   `include "soc_ctrl_tb_model.svh"

   soc_ctrl_top u_dut (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .paddr_i             (paddr),
      .pwdata_i            (pwdata),
      .pwrite_i            (pwrite),
      .psel_i              (psel),
      .penable_i           (penable),
      .prdata_o            (prdata),
      .pready_o            (pready),
      .pslverr_o           (pslverr),
      .bootsel_i           (bootsel),
      .fc_fetch_en_valid_i (fetch_valid),
      .fc_fetch_en_i       (fetch_en),
      .soc_jtag_reg_i      (jtag_in),
      .pad_mux_o           (pad_mux),
      .pad_cfg_o           (pad_cfg),
      .soc_jtag_reg_o      (jtag_out),
      .fc_bootaddr_o       (bootaddr),
      .fc_fetchen_o        (fetchen)
   );

   always #4 HCLK = ~HCLK;                    // 8 ns period

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input soc_word_u got, input soc_word_u exp);
      if (got.raw !== exp.raw)
         stop_on_error($sformatf("FAILED %0t %s got 0x%08h expected 0x%08h",
                                 $time, name, got.raw, exp.raw));
   endtask

   task automatic check_pad_mux(input string name, input pad_mux_t got, input pad_mux_t exp);
      if (got !== exp)
         stop_on_error($sformatf("FAILED %0t %s got %b expected %b", $time, name, got, exp));
   endtask

   task automatic check_pad_cfg(input string name, input pad_cfg_t got, input pad_cfg_t exp);
      if (got !== exp)
         stop_on_error($sformatf("FAILED %0t %s got %b expected %b", $time, name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_on_error($sformatf("FAILED %0t %s got %b expected %b", $time, name, got, exp));
   endtask

   task automatic await_ready();
      int cycles;
      cycles = 0;
      while (pready !== 1'b1)
      begin
         @(posedge HCLK);
         #1;
         cycles++;
         if (cycles > READY_TIMEOUT)
            stop_on_error("pready_o did not go high within the access phase timeout");
      end
   endtask

   // setup phase now, access phase after the next edge, done after the one after
   task automatic apb_write(input reg_idx_t idx, input logic [`SOC_DATA_W-1:0] data);
      paddr   = {{(`SOC_APB_ADDR_W-9){1'b0}}, idx, 2'b00};
      pwdata  = data;
      pwrite  = 1'b1;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge HCLK);
      #1;
      penable = 1'b1;
      await_ready();
      check_bit("pslverr_o", pslverr, 1'b0);
      @(posedge HCLK);                        // write lands here
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      model_write(idx, data);
   endtask

   task automatic apb_read(input reg_idx_t idx, output soc_word_u data);
      paddr   = {{(`SOC_APB_ADDR_W-9){1'b0}}, idx, 2'b00};
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge HCLK);
      #1;
      penable = 1'b1;
      await_ready();
      check_bit("pslverr_o", pslverr, 1'b0);
      data = prdata;                          // combinational, stable mid cycle
      @(posedge HCLK);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_and_compare(input reg_idx_t idx);
      soc_word_u rd;
      apb_read(idx, rd);
      check_word($sformatf("prdata_o[idx 0x%02h]", idx), rd, model_read(idx));
   endtask

   task automatic check_all_regs();
      for (int i = 0; i < 128; i++)
         read_and_compare(reg_idx_t'(i));     // unmapped ones expect zero
   endtask

   task automatic check_pad_outputs();
      for (int p = 0; p < `SOC_NUM_PADS; p++)
      begin
         check_pad_mux($sformatf("pad_mux_o[%0d]", p), pad_mux[p], m_mux[p]);
         check_pad_cfg($sformatf("pad_cfg_o[%0d]", p), pad_cfg[p], m_cfg[p]);
      end
   endtask

   task automatic check_side_outputs();
      check_word("fc_bootaddr_o", bootaddr, m_bootaddr);
      check_bit("fc_fetchen_o", fetchen, m_fetchen);
      check_word("soc_jtag_reg_o", 32'(jtag_out), 32'(m_jtag_out));
   endtask

   initial
   begin
      reg_idx_t               idx;
      logic [`SOC_DATA_W-1:0] data;
      void'($urandom(32'hccc5_af5f));
      HRESETn     = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      pwrite      = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      bootsel     = 2'b00;
      fetch_valid = 1'b0;
      fetch_en    = 1'b0;
      jtag_in     = '0;
      model_reset();
      repeat (10) @(posedge HCLK);
      #1;
      HRESETn = 1'b1;

      // reset values of every register and output
      check_all_regs();
      check_pad_outputs();
      check_side_outputs();

      repeat (40)
      begin
         if ($urandom_range(1, 0) == 0)
            idx = reg_idx_t'(`REG_PADFUN0 + $urandom_range(`SOC_NUM_PADFUN - 1, 0));
         else
            idx = reg_idx_t'(`REG_PADCFG0 + $urandom_range(`SOC_NUM_PADCFG - 1, 0));
         apb_write(idx, $urandom());
         check_pad_outputs();                 // one cycle after the write edge
         read_and_compare(idx);
      end

      repeat (8)
      begin
         apb_write(`REG_FCBOOT, $urandom());
         check_side_outputs();
         read_and_compare(`REG_FCBOOT);
      end

      // external override alone, then together with an apb write
      for (int k = 0; k < 2; k++)
      begin
         apb_write(`REG_FCFETCH, 32'(k));
         fetch_en    = ~k[0];
         fetch_valid = 1'b1;
         @(posedge HCLK);
         #1;
         m_fetchen = ~k[0];
         check_bit("fc_fetchen_o", fetchen, m_fetchen);
         apb_write(`REG_FCFETCH, 32'(k));     // override still valid here
         fetch_valid = 1'b0;
         check_bit("fc_fetchen_o", fetchen, m_fetchen);
         read_and_compare(`REG_FCFETCH);
      end

      data = $urandom();
      apb_write(`REG_CORESTATUS, data);
      read_and_compare(`REG_CORESTATUS);
      read_and_compare(`REG_CS_RO);
      apb_write(`REG_CS_RO, ~data);
      read_and_compare(`REG_CORESTATUS);
      read_and_compare(`REG_CS_RO);

      read_and_compare(`REG_INFO);
      repeat (6)
      begin
         jtag_in = `SOC_JTAG_W'($urandom());
         bootsel = 2'($urandom());
         repeat (3) @(posedge HCLK);
         #1;
         m_jtag_in = jtag_in;                 // both sync stages settled
         m_bootsel = bootsel;
         apb_write(`REG_JTAGREG, $urandom());
         check_side_outputs();
         read_and_compare(`REG_JTAGREG);
         read_and_compare(`REG_BOOTSEL);
      end

      repeat (40)
      begin
         idx = reg_idx_t'($urandom_range(127, 0));
         if (!model_mapped(idx))
         begin
            apb_write(idx, $urandom());
            read_and_compare(idx);
         end
      end
      check_all_regs();
      check_pad_outputs();
      check_side_outputs();

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// File: sources.f
+incdir+design
+incdir+sim
design/soc_ctrl_pkg.sv
design/apb_reg_decode.sv
design/pad_ctrl_regs.sv
design/fc_boot_regs.sv
design/soc_status_regs.sv
design/soc_ctrl_top.sv
sim/soc_ctrl_tb.sv
